/* list.f */
rtl/wb_pkg.sv
rtl/result_queue.sv
rtl/fair_2way_arbiter.sv
rtl/wb_skid_buffer.sv
rtl/wb_merge_top.sv
sim/wb_merge_assert.sv
sim/tb_wb_merge.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

# Build the testbench together with the DUT and the bound assertions
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wb_merge -f list.f -o tb_wb_merge

# Run and keep the log for the verdict
./obj_dir/tb_wb_merge | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"

/* sim/tb_wb_merge.sv */
`timescale 1ns/1ps

module tb_wb_merge;
    import wb_pkg::*;

    // Cycles any single wait may take
    localparam int unsigned TIMEOUT = 200;

    logic       clk;
    logic       rst_n;
    logic       a_valid;
    logic       a_ready;
    wb_result_t a_result;
    logic       b_valid;
    logic       b_ready;
    wb_result_t b_result;
    logic       wb_valid;
    logic       wb_ready;
    wb_result_t wb_result;

    // Scoreboard, one expected queue per source
    wb_result_t  exp_a[$];
    wb_result_t  exp_b[$];
    int unsigned acc_cycle_a[$];
    // Source of every result seen on the writeback port, 0 for A
    bit          out_src[$];
    int unsigned cycle_cnt = 0;
    int          errors = 0;
    int          accepted = 0;
    bit          check_latency = 1'b0;
    bit          stall_seen = 1'b0;
    wb_result_t  held;

    wb_merge_top u_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .a_valid_i   (a_valid),
        .a_ready_o   (a_ready),
        .a_result_i  (a_result),
        .b_valid_i   (b_valid),
        .b_ready_o   (b_ready),
        .b_result_i  (b_result),
        .wb_valid_o  (wb_valid),
        .wb_ready_i  (wb_ready),
        .wb_result_o (wb_result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic finish_run();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    // Tag ranges: A uses 0..7, B uses 8..15
    function automatic wb_result_t make_result(input bit src, input int unsigned idx);
        wb_result_t r;
        r.tag   = {src, idx[2:0]};
        r.rd    = reg_idx_t'($urandom);
        r.value = $urandom;
        return r;
    endfunction

    // Holds valid and data until the queue takes the result
    task automatic send_result(input bit src, input wb_result_t r);
        int unsigned waited = 0;
        if (src) begin
            b_valid  = 1'b1;
            b_result = r;
        end else begin
            a_valid  = 1'b1;
            a_result = r;
        end
        // Ready is settled by mid-cycle
        @(negedge clk);
        while (!(src ? b_ready : a_ready)) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: source %0d input ready never came back", src);
                errors++;
                finish_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        if (src) begin
            b_valid = 1'b0;
            exp_b.push_back(r);
        end else begin
            a_valid = 1'b0;
            exp_a.push_back(r);
            acc_cycle_a.push_back(cycle_cnt);
        end
        accepted++;
    endtask

    task automatic send_burst(input bit src, input int unsigned n);
        for (int unsigned i = 0; i < n; i++) begin
            send_result(src, make_result(src, i));
        end
    endtask

    // Returns at posedge+2 once both input sides are blocked
    task automatic wait_inputs_blocked();
        int unsigned waited = 0;
        @(negedge clk);
        while (a_ready || b_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: input readys stayed high with the writeback port stalled");
                errors++;
                finish_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain();
        int unsigned waited = 0;
        wb_ready = 1'b1;
        while (exp_a.size() + exp_b.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: accepted results never left the writeback port");
                errors++;
                finish_run();
            end
        end
        @(posedge clk);
        #2;
    endtask

    // ----------------------------------------------------------------------
    // Monitor
    // ----------------------------------------------------------------------
    task automatic check_output();
        wb_result_t  want;
        bit          src;
        int unsigned acc;
        src = wb_result.tag[3];
        out_src.push_back(src);
        if ((src ? exp_b.size() : exp_a.size()) == 0) begin
            $display("Result with tag %h came out with nothing pending on its source",
                     wb_result.tag);
            errors++;
            return;
        end
        if (src) begin
            want = exp_b.pop_front();
        end else begin
            want = exp_a.pop_front();
            acc  = acc_cycle_a.pop_front();
            // Idle path: accepted at edge N, taken at edge N+2
            if (check_latency) begin
                assert (cycle_cnt + 1 - acc == 2) else begin
                    $display("FAILED latency of tag %h: got %h expected %h",
                             want.tag, cycle_cnt + 1 - acc, 2);
                    errors++;
                end
            end
        end
        assert (wb_result.tag == want.tag) else begin
            $display("FAILED wb_result_o.tag: got %h expected %h", wb_result.tag, want.tag);
            errors++;
        end
        assert (wb_result.rd == want.rd) else begin
            $display("FAILED wb_result_o.rd: got %h expected %h", wb_result.rd, want.rd);
            errors++;
        end
        assert (wb_result.value == want.value) else begin
            $display("FAILED wb_result_o.value: got %h expected %h",
                     wb_result.value, want.value);
            errors++;
        end
    endtask

    // Mid-cycle sampling, transfer happens at the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            // Stalled result must stay put
            if (stall_seen) begin
                assert (wb_valid && wb_result == held) else begin
                    $display("FAILED wb_result_o under stall: got %h held %h", wb_result, held);
                    errors++;
                end
            end
            stall_seen = wb_valid && !wb_ready;
            held       = wb_result;
            if (wb_valid && wb_ready) begin
                check_output();
            end
        end
    end

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_reset_state();
        @(negedge clk);
        assert (!wb_valid && a_ready && b_ready) else begin
            $display("FAILED reset state: wb_valid_o %h a_ready_o %h b_ready_o %h",
                     wb_valid, a_ready, b_ready);
            errors++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic test_single_source();
        wb_ready      = 1'b1;
        check_latency = 1'b1;
        send_burst(1'b0, 8);
        wait_drain();
        check_latency = 1'b0;
    endtask

    task automatic test_fair_alternation();
        wb_ready = 1'b0;
        out_src.delete();
        fork
            send_burst(1'b0, 8);
            send_burst(1'b1, 8);
            begin
                // Preload done once queues and skid are full
                wait_inputs_blocked();
                wb_ready = 1'b1;
            end
        join
        wait_drain();
        assert (out_src.size() == 16) else begin
            $display("FAILED result count: got %h expected %h", out_src.size(), 16);
            errors++;
        end
        // First conflict since reset goes to A
        foreach (out_src[i]) begin
            assert (out_src[i] == i[0]) else begin
                $display("FAILED source at output %0d: got %h expected %h",
                         i, out_src[i], i[0]);
                errors++;
            end
        end
    endtask

    task automatic test_back_pressure();
        bit done = 1'b0;
        fork
            begin
                fork
                    send_burst(1'b0, 12);
                    send_burst(1'b1, 12);
                join
                done = 1'b1;
            end
            // Port stalls about one cycle in four
            while (!done) begin
                wb_ready = ($urandom % 4) != 0;
                @(posedge clk);
                #2;
            end
        join
        wait_drain();
    endtask

    task automatic test_full_queues();
        wb_ready = 1'b0;
        accepted = 0;
        fork
            send_burst(1'b0, 4);
            send_burst(1'b1, 4);
            begin
                wait_inputs_blocked();
                // Two per queue plus two in the skid stage
                assert (accepted <= 6) else begin
                    $display("FAILED accepted while stalled: got %h expected at most %h",
                             accepted, 6);
                    errors++;
                end
                wb_ready = 1'b1;
            end
        join
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h4678e7d5));
        rst_n    = 1'b0;
        a_valid  = 1'b0;
        a_result = '0;
        b_valid  = 1'b0;
        b_result = '0;
        wb_ready = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_single_source();
        test_fair_alternation();
        test_back_pressure();
        test_full_queues();
        finish_run();
    end

endmodule

/* sim/wb_merge_assert.sv */
`timescale 1ns/1ps

module arb_checks (
    input logic clk_i,
    input logic rst_n_i,
    input logic valid_a_i,
    input logic valid_b_i,
    input logic ready_i,
    input logic ready_a_i,
    input logic ready_b_i
);
    // Both sources pending with room downstream
    logic conflict_go;

    assign conflict_go = valid_a_i && valid_b_i && ready_i;

    // One grant at most
    one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ready_a_i && ready_b_i))
        else $error("both sources granted in one cycle");

    // Grant only to a source with a result
    grant_a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ready_a_i |-> valid_a_i)
        else $error("source A granted without a pending result");
    grant_b_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ready_b_i |-> valid_b_i)
        else $error("source B granted without a pending result");

    // Back-to-back conflicts flip the winner
    conflict_alternates: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        conflict_go && $past(conflict_go) |-> ready_a_i != $past(ready_a_i))
        else $error("same source won two conflicts in a row");

endmodule

bind fair_2way_arbiter arb_checks u_arb_checks (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_a_i (valid_a_i),
    .valid_b_i (valid_b_i),
    .ready_i   (ready_i),
    .ready_a_i (ready_a_o),
    .ready_b_i (ready_b_o)
);

/* rtl/wb_merge_top.sv */
`timescale 1ns/1ps

module wb_merge_top (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Execution unit A
    input  logic               a_valid_i,
    output logic               a_ready_o,
    input  wb_pkg::wb_result_t a_result_i,

    // Execution unit B
    input  logic               b_valid_i,
    output logic               b_ready_o,
    input  wb_pkg::wb_result_t b_result_i,

    // Register file writeback port
    output logic               wb_valid_o,
    input  logic               wb_ready_i,
    output wb_pkg::wb_result_t wb_result_o
);
    import wb_pkg::*;

    // ----------------------------------------------------------------------
    // Queue heads into the arbiter
    // ----------------------------------------------------------------------
    logic       qa_valid;
    logic       qa_ready;
    wb_result_t qa_data;
    logic       qb_valid;
    logic       qb_ready;
    wb_result_t qb_data;

    // Arbiter to skid stage
    logic       arb_valid;
    logic       arb_ready;
    wb_result_t arb_data;

    result_queue u_queue_a (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (a_valid_i),
        .push_ready_o (a_ready_o),
        .push_data_i  (a_result_i),
        .pop_valid_o  (qa_valid),
        .pop_ready_i  (qa_ready),
        .pop_data_o   (qa_data)
    );

    result_queue u_queue_b (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (b_valid_i),
        .push_ready_o (b_ready_o),
        .push_data_i  (b_result_i),
        .pop_valid_o  (qb_valid),
        .pop_ready_i  (qb_ready),
        .pop_data_o   (qb_data)
    );

    fair_2way_arbiter #(
        .DATA_T (wb_result_t)
    ) u_arb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_a_i (qa_valid),
        .valid_b_i (qb_valid),
        .ready_i   (arb_ready),
        .valid_o   (arb_valid),
        .ready_a_o (qa_ready),
        .ready_b_o (qb_ready),
        .data_a_i  (qa_data),
        .data_b_i  (qb_data),
        .data_o    (arb_data)
    );

    // Output stage, registered ready back to the arbiter
    wb_skid_buffer u_skid (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (arb_valid),
        .in_ready_o  (arb_ready),
        .in_data_i   (arb_data),
        .out_valid_o (wb_valid_o),
        .out_ready_i (wb_ready_i),
        .out_data_o  (wb_result_o)
    );

endmodule

/* rtl/wb_skid_buffer.sv */
`timescale 1ns/1ps

module wb_skid_buffer (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Upstream
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  wb_pkg::wb_result_t in_data_i,

    // Writeback port
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output wb_pkg::wb_result_t out_data_o
);
    import wb_pkg::*;

    // Main stage drives the port, skid catches the overflow
    wb_result_t main_q;
    wb_result_t skid_q;
    logic       main_valid_q;
    logic       skid_valid_q;
    // Registered ready, low only with both stages full
    logic       in_ready_q;

    logic push;
    logic pop;

    assign push = in_valid_i && in_ready_q;
    assign pop  = main_valid_q && out_ready_i;

    assign in_ready_o  = in_ready_q;
    assign out_valid_o = main_valid_q;
    assign out_data_o  = main_q;

    // Occupancy and ready flags
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b1;
        end else begin
            if (pop && skid_valid_q) begin
                // Skid drains into main, no push possible while full
                skid_valid_q <= 1'b0;
                in_ready_q   <= 1'b1;
            end else if (pop) begin
                // Main refilled only by a push
                main_valid_q <= push;
            end else if (push && main_valid_q) begin
                // Port stalled, input parks in skid
                skid_valid_q <= 1'b1;
                in_ready_q   <= 1'b0;
            end else if (push) begin
                main_valid_q <= 1'b1;
            end
        end
    end

    // Payload moves
    always_ff @(posedge clk_i) begin
        if (pop && skid_valid_q) begin
            main_q <= skid_q;
        end else if (push && (pop || !main_valid_q)) begin
            main_q <= in_data_i;
        end
        if (push && main_valid_q && !pop) begin
            skid_q <= in_data_i;
        end
    end

endmodule

/* rtl/fair_2way_arbiter.sv */
`timescale 1ns/1ps

module fair_2way_arbiter #(
    parameter type DATA_T = logic
) (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // Handshake
    input  logic  valid_a_i,
    input  logic  valid_b_i,
    input  logic  ready_i,
    output logic  valid_o,
    output logic  ready_a_o,
    output logic  ready_b_o,

    // Payload
    input  DATA_T data_a_i,
    input  DATA_T data_b_i,
    output DATA_T data_o
);
    // Set when A took the most recent conflict
    logic a_won_last_q;
    // Source picked this cycle
    logic sel_a;
    logic conflict;

    assign conflict = valid_a_i && valid_b_i;

    // ----------------------------------------------------------------------
    // Source selection
    // ----------------------------------------------------------------------
    always_comb begin
        // Lone B, or B's turn on a conflict
        if (conflict) begin
            sel_a = ~a_won_last_q;
        end else begin
            sel_a = ~valid_b_i;
        end
    end

    // Grants only with downstream room
    assign ready_a_o = ready_i && valid_a_i && sel_a;
    assign ready_b_o = ready_i && valid_b_i && !sel_a;

    // Either source has something pending
    assign valid_o = valid_a_i || valid_b_i;

    // Payload follows the pick, independent of ready_i
    assign data_o = sel_a ? data_a_i : data_b_i;

    // ----------------------------------------------------------------------
    // Conflict history
    // ----------------------------------------------------------------------
    // Cleared so A wins the first conflict
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a_won_last_q <= 1'b0;
        end else if (conflict && ready_i) begin
            a_won_last_q <= ~a_won_last_q;
        end
    end

endmodule

/* rtl/result_queue.sv */
`timescale 1ns/1ps

module result_queue (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Execution unit side
    input  logic               push_valid_i,
    output logic               push_ready_o,
    input  wb_pkg::wb_result_t push_data_i,

    // Arbiter side
    output logic               pop_valid_o,
    input  logic               pop_ready_i,
    output wb_pkg::wb_result_t pop_data_o
);
    import wb_pkg::*;

    // Storage slots, payload only
    wb_result_t mem_q [QUEUE_DEPTH];

    qptr_t wr_ptr_q;
    qptr_t rd_ptr_q;
    qcnt_t count_q;

    logic push;
    logic pop;

    // ----------------------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------------------

    // Something to show as soon as one entry is held
    assign pop_valid_o  = (count_q != '0);
    // A pop on a full queue frees the slot at the same edge
    assign push_ready_o = (count_q != qcnt_t'(QUEUE_DEPTH)) || pop_ready_i;

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    // Head entry goes straight out
    assign pop_data_o = mem_q[rd_ptr_q];

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Circular wrap at the last slot
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Count moves only when exactly one side fires
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Slot write
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

/* rtl/wb_pkg.sv */
package wb_pkg;

    // ----------------------------------------------------------------------
    // Field widths
    // ----------------------------------------------------------------------

    // Architectural register file index
    localparam int unsigned REG_IDX_W = 5;
    // Machine word
    localparam int unsigned XLEN      = 32;
    // Reorder buffer slot id
    localparam int unsigned ROB_TAG_W = 4;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      xlen_word_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // One result from an execution unit, 41 bits
    typedef struct packed {
        rob_tag_t   tag;
        reg_idx_t   rd;
        xlen_word_t value;
    } wb_result_t;

    // ----------------------------------------------------------------------
    // Input queue sizing
    // ----------------------------------------------------------------------

    // Entries per source queue
    localparam int unsigned QUEUE_DEPTH = 2;
    // Slot pointer and occupancy counter widths
    localparam int unsigned QPTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned QCNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [QCNT_W-1:0] qcnt_t;

endpackage
